// File: source/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int unsigned ADDR_W        = 32;
    localparam int unsigned WAY_NUM       = 2;
    localparam int unsigned SET_NUM       = 128;
    localparam int unsigned LINE_WORDS    = 8;
    localparam int unsigned OFFSET_W      = 5;
    localparam int unsigned INDEX_W       = 7;
    localparam int unsigned TAG_W         = 20;
    localparam int unsigned ROW_W         = 64;
    localparam int unsigned ROWS_PER_LINE = 4;

    // address error on fetch
    localparam logic [5:0] ECODE_ADEF = 6'h08;

    // pc split into cache fields
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [1:0]         row;
        logic               word;
        logic [1:0]         byte_sel;
    } fetch_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        fetch_fields_t     f;
    } fetch_addr_u;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic [WAY_NUM-1:0] way_vec_t;

    typedef logic [1:0] fetch_mask_t;

    // lower address word sits in bits 31:0
    typedef logic [ROW_W-1:0] inst_pair_t;

    typedef struct packed {
        fetch_addr_u pc;
        fetch_mask_t mask;
    } miss_req_t;

endpackage

`default_nettype wire

// File: source/icache_fill_if.sv
`default_nettype none

interface icache_fill_if;
    import icache_pkg::*;

    logic [INDEX_W-1:0] fill_index;
    logic [1:0]         fill_row;
    inst_pair_t         fill_data;
    tag_entry_t         fill_tag;
    way_vec_t           fill_way_we;

    modport writer (
        output fill_index, fill_row, fill_data, fill_tag, fill_way_we
    );

    modport array (
        input fill_index, fill_row, fill_data, fill_tag, fill_way_we
    );

endinterface

`default_nettype wire

// File: source/icache_lookup.sv
`default_nettype none

module icache_lookup (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush_i,
    input  logic                           stall_i,
    input  logic                           fetch_valid_i,
    input  icache_pkg::fetch_addr_u        fetch_pc_i,
    input  icache_pkg::fetch_mask_t        fetch_mask_i,
    output logic                           fetch_ready_o,
    output logic [icache_pkg::INDEX_W-1:0] rd_index_o,
    output logic [1:0]                     rd_row_o,
    output logic                           s1_valid_o,
    output icache_pkg::fetch_addr_u        s1_pc_o,
    output icache_pkg::fetch_mask_t        s1_mask_o
);
    import icache_pkg::*;

    logic        valid_q;
    fetch_addr_u pc_q;
    fetch_mask_t mask_q;
    fetch_addr_u rd_pc;

    // nothing is taken while refilling or in a redirect cycle
    assign fetch_ready_o = !stall_i && !flush_i;

    // held pc keeps the array pointed at the stalled line
    assign rd_pc      = stall_i ? pc_q : fetch_pc_i;
    assign rd_index_o = rd_pc.f.index;
    assign rd_row_o   = rd_pc.f.row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i || stall_i) begin
            // stalled entry is answered by the refill engine, drop it here
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_q   <= fetch_pc_i;
            mask_q <= fetch_mask_i;
        end
    end

    assign s1_valid_o = valid_q;
    assign s1_pc_o    = pc_q;
    assign s1_mask_o  = mask_q;

endmodule

`default_nettype wire

// File: source/icache_arrays.sv
`default_nettype none

module icache_arrays (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [icache_pkg::INDEX_W-1:0]                    rd_index_i,
    input  logic [1:0]                                        rd_row_i,
    icache_fill_if.array                                      fill,
    output icache_pkg::tag_entry_t [icache_pkg::WAY_NUM-1:0]  rd_tags_o,
    output icache_pkg::inst_pair_t [icache_pkg::WAY_NUM-1:0]  rd_data_o
);
    import icache_pkg::*;

    localparam int unsigned ROW_ADDR_W = INDEX_W + $clog2(ROWS_PER_LINE);

    logic [ROW_ADDR_W-1:0] rd_row_addr;
    logic [ROW_ADDR_W-1:0] wr_row_addr;
    logic                  tag_fwd;
    logic                  data_fwd;

    assign rd_row_addr = {rd_index_i, rd_row_i};
    assign wr_row_addr = {fill.fill_index, fill.fill_row};

    // same-cycle write to the read address wins
    assign tag_fwd  = fill.fill_index == rd_index_i;
    assign data_fwd = wr_row_addr == rd_row_addr;

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        logic [TAG_W-1:0] tag_mem [SET_NUM];
        inst_pair_t       data_mem [SET_NUM * ROWS_PER_LINE];
        logic [SET_NUM-1:0] valid_q;
        logic             valid_rd_q;
        logic [TAG_W-1:0] tag_rd_q;
        inst_pair_t       data_rd_q;
        logic             we;

        assign we = fill.fill_way_we[w];

        // valid bits need a known state after reset
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_q    <= '0;
                valid_rd_q <= 1'b0;
            end else begin
                if (we) begin
                    valid_q[fill.fill_index] <= fill.fill_tag.valid;
                end
                if (we && tag_fwd) begin
                    valid_rd_q <= fill.fill_tag.valid;
                end else begin
                    valid_rd_q <= valid_q[rd_index_i];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (we) begin
                tag_mem[fill.fill_index] <= fill.fill_tag.tag;
                data_mem[wr_row_addr]    <= fill.fill_data;
            end
            if (we && tag_fwd) begin
                tag_rd_q <= fill.fill_tag.tag;
            end else begin
                tag_rd_q <= tag_mem[rd_index_i];
            end
            if (we && data_fwd) begin
                data_rd_q <= fill.fill_data;
            end else begin
                data_rd_q <= data_mem[rd_row_addr];
            end
        end

        assign rd_tags_o[w] = {valid_rd_q, tag_rd_q};
        assign rd_data_o[w] = data_rd_q;
    end

endmodule

`default_nettype wire

// File: source/icache_hit_check.sv
`default_nettype none

module icache_hit_check (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              flush_i,
    input  logic                                              s1_valid_i,
    input  icache_pkg::fetch_addr_u                           s1_pc_i,
    input  icache_pkg::fetch_mask_t                           s1_mask_i,
    input  icache_pkg::tag_entry_t [icache_pkg::WAY_NUM-1:0]  rd_tags_i,
    input  icache_pkg::inst_pair_t [icache_pkg::WAY_NUM-1:0]  rd_data_i,
    output logic                                              miss_o,
    output icache_pkg::miss_req_t                             miss_req_o,
    output logic                                              hit_valid_o,
    output icache_pkg::fetch_addr_u                           hit_pc_o,
    output icache_pkg::inst_pair_t                            hit_data_o,
    output icache_pkg::fetch_mask_t                           hit_mask_o,
    output logic                                              hit_exc_o,
    output logic [5:0]                                        hit_ecode_o
);
    import icache_pkg::*;

    way_vec_t  way_hit;
    logic      active;
    logic      misaligned;
    miss_req_t miss_req_q;

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_cmp
        assign way_hit[w] = rd_tags_i[w].valid && (rd_tags_i[w].tag == s1_pc_i.f.tag);
    end

    // empty mask means no slot wants an answer
    assign active     = s1_valid_i && !flush_i && (|s1_mask_i);
    assign misaligned = |s1_pc_i.f.byte_sel;

    assign hit_valid_o = active && (misaligned || (|way_hit));
    assign miss_o      = active && !misaligned && !(|way_hit);

    assign hit_pc_o    = s1_pc_i;
    assign hit_mask_o  = s1_mask_i;
    assign hit_data_o  = way_hit[1] ? rd_data_i[1] : rd_data_i[0];
    assign hit_exc_o   = misaligned;
    assign hit_ecode_o = misaligned ? ECODE_ADEF : 6'd0;

    // refill engine works from this copy for the whole line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miss_req_q <= '0;
        end else if (miss_o) begin
            miss_req_q.pc   <= s1_pc_i;
            miss_req_q.mask <= s1_mask_i;
        end
    end

    assign miss_req_o = miss_req_q;

endmodule

`default_nettype wire

// File: source/icache_refill.sv
`default_nettype none

module icache_refill (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    miss_i,
    input  icache_pkg::miss_req_t   miss_req_i,
    input  logic                    cacop_valid_i,
    input  icache_pkg::fetch_addr_u cacop_addr_i,
    output logic                    cacop_done_o,
    output logic                    mem_req_o,
    output logic [31:0]             mem_addr_o,
    output logic [7:0]              mem_len_o,
    input  logic                    mem_ack_i,
    input  logic                    mem_data_valid_i,
    input  logic [31:0]             mem_data_i,
    icache_fill_if.writer           fill,
    output logic                    stall_o,
    output logic                    refill_valid_o,
    output icache_pkg::fetch_addr_u refill_pc_o,
    output icache_pkg::inst_pair_t  refill_data_o,
    output icache_pkg::fetch_mask_t refill_mask_o
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_RECV
    } state_t;

    state_t             state_q;
    logic [2:0]         cnt_q;
    logic [31:0]        lo_word_q;
    inst_pair_t         pair_q;
    logic               done_q;
    logic [SET_NUM-1:0] victim_q;
    fetch_addr_u        mpc;
    logic               victim;
    logic               row_done;
    logic               last_word;

    assign mpc       = miss_req_i.pc;
    assign victim    = victim_q[mpc.f.index];
    assign row_done  = (state_q == S_RECV) && mem_data_valid_i && cnt_q[0];
    assign last_word = row_done && (cnt_q == 3'(LINE_WORDS - 1));

    // maintenance beats a miss seen in the same cycle
    assign cacop_done_o = (state_q == S_IDLE) && cacop_valid_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= S_IDLE;
            cnt_q    <= '0;
            done_q   <= 1'b0;
            victim_q <= '0;
        end else begin
            done_q <= last_word;
            case (state_q)
                S_IDLE: begin
                    if (miss_i && !cacop_valid_i) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= S_RECV;
                        cnt_q   <= '0;
                    end
                end
                S_RECV: begin
                    if (mem_data_valid_i) begin
                        cnt_q <= cnt_q + 3'd1;
                    end
                    if (last_word) begin
                        state_q                <= S_IDLE;
                        victim_q[mpc.f.index] <= !victim;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // even words wait here for their odd partner
    always_ff @(posedge clk) begin
        if ((state_q == S_RECV) && mem_data_valid_i && !cnt_q[0]) begin
            lo_word_q <= mem_data_i;
        end
        if (row_done && (cnt_q[2:1] == mpc.f.row)) begin
            pair_q <= {mem_data_i, lo_word_q};
        end
    end

    always_comb begin
        fill.fill_index  = cacop_addr_i.f.index;
        fill.fill_row    = cacop_addr_i.f.row;
        fill.fill_data   = {mem_data_i, lo_word_q};
        fill.fill_tag    = '0;
        fill.fill_way_we = '0;
        if (state_q == S_RECV) begin
            fill.fill_index     = mpc.f.index;
            fill.fill_row       = cnt_q[2:1];
            fill.fill_tag.valid = 1'b1;
            fill.fill_tag.tag   = mpc.f.tag;
            if (row_done) begin
                fill.fill_way_we = way_vec_t'(1) << victim;
            end
        end else if (cacop_done_o) begin
            // index invalidate, way picked by address bit 0
            fill.fill_way_we = way_vec_t'(1) << cacop_addr_i.raw[0];
        end
    end

    assign mem_req_o  = state_q == S_REQ;
    assign mem_addr_o = {mpc.f.tag, mpc.f.index, {OFFSET_W{1'b0}}};
    assign mem_len_o  = 8'(LINE_WORDS);

    assign stall_o        = (state_q != S_IDLE) || miss_i;
    assign refill_valid_o = done_q;
    assign refill_pc_o    = mpc;
    assign refill_data_o  = pair_q;
    assign refill_mask_o  = miss_req_i.mask;

endmodule

`default_nettype wire

// File: source/icache_top.sv
`default_nettype none

module icache_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_pc_i,
    input  logic [1:0]  fetch_mask_i,
    output logic        fetch_ready_o,
    output logic        inst_valid_o,
    output logic [31:0] inst_pc_o,
    output logic [63:0] inst_data_o,
    output logic [1:0]  inst_mask_o,
    output logic        inst_exc_o,
    output logic [5:0]  inst_ecode_o,
    output logic        mem_req_o,
    output logic [31:0] mem_addr_o,
    output logic [7:0]  mem_len_o,
    input  logic        mem_ack_i,
    input  logic        mem_data_valid_i,
    input  logic [31:0] mem_data_i,
    input  logic        cacop_valid_i,
    input  logic [31:0] cacop_addr_i,
    output logic        cacop_done_o
);
    import icache_pkg::*;

    logic                          stall;
    logic [INDEX_W-1:0]            rd_index;
    logic [1:0]                    rd_row;
    logic                          s1_valid;
    fetch_addr_u                   s1_pc;
    fetch_mask_t                   s1_mask;
    tag_entry_t [WAY_NUM-1:0]      rd_tags;
    inst_pair_t [WAY_NUM-1:0]      rd_data;
    logic                          miss;
    miss_req_t                     miss_req;
    logic                          hit_valid;
    fetch_addr_u                   hit_pc;
    inst_pair_t                    hit_data;
    fetch_mask_t                   hit_mask;
    logic                          hit_exc;
    logic [5:0]                    hit_ecode;
    logic                          refill_valid;
    fetch_addr_u                   refill_pc;
    inst_pair_t                    refill_data;
    fetch_mask_t                   refill_mask;

    icache_fill_if fill_bus ();

    icache_lookup u_lookup (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .stall_i       (stall),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_addr_u'(fetch_pc_i)),
        .fetch_mask_i  (fetch_mask_i),
        .fetch_ready_o (fetch_ready_o),
        .rd_index_o    (rd_index),
        .rd_row_o      (rd_row),
        .s1_valid_o    (s1_valid),
        .s1_pc_o       (s1_pc),
        .s1_mask_o     (s1_mask)
    );

    icache_arrays u_arrays (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_i (rd_index),
        .rd_row_i   (rd_row),
        .fill       (fill_bus.array),
        .rd_tags_o  (rd_tags),
        .rd_data_o  (rd_data)
    );

    icache_hit_check u_hit_check (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .s1_valid_i  (s1_valid),
        .s1_pc_i     (s1_pc),
        .s1_mask_i   (s1_mask),
        .rd_tags_i   (rd_tags),
        .rd_data_i   (rd_data),
        .miss_o      (miss),
        .miss_req_o  (miss_req),
        .hit_valid_o (hit_valid),
        .hit_pc_o    (hit_pc),
        .hit_data_o  (hit_data),
        .hit_mask_o  (hit_mask),
        .hit_exc_o   (hit_exc),
        .hit_ecode_o (hit_ecode)
    );

    icache_refill u_refill (
        .clk              (clk),
        .rst_n            (rst_n),
        .miss_i           (miss),
        .miss_req_i       (miss_req),
        .cacop_valid_i    (cacop_valid_i),
        .cacop_addr_i     (fetch_addr_u'(cacop_addr_i)),
        .cacop_done_o     (cacop_done_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_len_o        (mem_len_o),
        .mem_ack_i        (mem_ack_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .fill             (fill_bus.writer),
        .stall_o          (stall),
        .refill_valid_o   (refill_valid),
        .refill_pc_o      (refill_pc),
        .refill_data_o    (refill_data),
        .refill_mask_o    (refill_mask)
    );

    // stage 1 is empty whenever the refill answers
    assign inst_valid_o = hit_valid || refill_valid;
    assign inst_pc_o    = refill_valid ? refill_pc.raw : hit_pc.raw;
    assign inst_data_o  = refill_valid ? refill_data : hit_data;
    assign inst_mask_o  = refill_valid ? refill_mask : hit_mask;
    assign inst_exc_o   = !refill_valid && hit_exc;
    assign inst_ecode_o = refill_valid ? 6'd0 : hit_ecode;

endmodule

`default_nettype wire

// File: tests/icache_tb.sv
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int TIMEOUT = 500;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        flush_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_pc_i;
    logic [1:0]  fetch_mask_i;
    logic        fetch_ready_o;
    logic        inst_valid_o;
    logic [31:0] inst_pc_o;
    logic [63:0] inst_data_o;
    logic [1:0]  inst_mask_o;
    logic        inst_exc_o;
    logic [5:0]  inst_ecode_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic [7:0]  mem_len_o;
    logic        mem_ack_i;
    logic        mem_data_valid_i;
    logic [31:0] mem_data_i;
    logic        cacop_valid_i;
    logic [31:0] cacop_addr_i;
    logic        cacop_done_o;

    // pc of the fetch in progress, for the bus address check
    logic [31:0] line_pc;
    int          bus_reqs = 0;

    // pending back-to-back hit stream
    logic [31:0] bq_pc[$];
    fetch_mask_t bq_mask[$];
    inst_pair_t  bq_data[$];

    icache_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_mask_i     (fetch_mask_i),
        .fetch_ready_o    (fetch_ready_o),
        .inst_valid_o     (inst_valid_o),
        .inst_pc_o        (inst_pc_o),
        .inst_data_o      (inst_data_o),
        .inst_mask_o      (inst_mask_o),
        .inst_exc_o       (inst_exc_o),
        .inst_ecode_o     (inst_ecode_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_len_o        (mem_len_o),
        .mem_ack_i        (mem_ack_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .cacop_valid_i    (cacop_valid_i),
        .cacop_addr_i     (cacop_addr_i),
        .cacop_done_o     (cacop_done_o)
    );

    always #5 clk = ~clk;

    task automatic flag_mismatch(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_pair(input inst_pair_t got, input inst_pair_t exp);
        if (got !== exp) begin
            flag_mismatch($sformatf("instruction pair %h, expected %h", got, exp));
        end
    endtask

    task automatic exception_check(input logic got_exc, input logic [5:0] got_ecode,
                                   input logic exp_exc);
        logic [5:0] exp_ecode;
        exp_ecode = exp_exc ? ECODE_ADEF : 6'd0;
        if (got_exc !== exp_exc || got_ecode !== exp_ecode) begin
            flag_mismatch($sformatf("exception %b code %h, expected %b code %h",
                                    got_exc, got_ecode, exp_exc, exp_ecode));
        end
    endtask

    task automatic echo_check(input fetch_addr_u got_pc, input fetch_addr_u exp_pc,
                              input fetch_mask_t got_mask, input fetch_mask_t exp_mask);
        if (got_pc.raw !== exp_pc.raw || got_mask !== exp_mask) begin
            flag_mismatch($sformatf("response pc %h mask %b, expected pc %h mask %b",
                                    got_pc.raw, got_mask, exp_pc.raw, exp_mask));
        end
    endtask

    task automatic fill_count_check(input int got, input int exp);
        if (got != exp) begin
            flag_mismatch($sformatf("%0d line refills, expected %0d", got, exp));
        end
    endtask

    // holds fetch_valid_i until the cache takes the request
    task automatic await_ready();
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken  = fetch_ready_o;
            waited = waited + 1;
            if (!taken && waited > TIMEOUT) begin
                abort_run("fetch request was never accepted");
            end
            next_cycle();
        end
    endtask

    task automatic issue_fetch(input logic [31:0] pc, input fetch_mask_t mask,
                               input logic exc, input int fill, input inst_pair_t pair);
        int          start;
        int          waited;
        logic        seen;
        fetch_addr_u got_pc;
        inst_pair_t  got_data;
        fetch_mask_t got_mask;
        logic        got_exc;
        logic [5:0]  got_ecode;
        start         = bus_reqs;
        waited        = 0;
        seen          = 1'b0;
        line_pc       = pc;
        fetch_valid_i = 1'b1;
        fetch_pc_i    = pc;
        fetch_mask_i  = mask;
        await_ready();
        fetch_valid_i = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (inst_valid_o) begin
                seen      = 1'b1;
                got_pc    = inst_pc_o;
                got_data  = inst_data_o;
                got_mask  = inst_mask_o;
                got_exc   = inst_exc_o;
                got_ecode = inst_ecode_o;
            end else begin
                waited = waited + 1;
                if (waited > TIMEOUT) begin
                    abort_run($sformatf("no response to fetch of pc %h", pc));
                end
            end
            next_cycle();
        end
        // hits and exceptions answer in the cycle after acceptance
        if (fill == 0 && waited != 0) begin
            flag_mismatch($sformatf("hit response %0d cycles late", waited));
        end
        fill_count_check(bus_reqs - start, fill);
        echo_check(got_pc, pc, got_mask, mask);
        exception_check(got_exc, got_ecode, exc);
        if (!exc) begin
            compare_pair(got_data, pair);
        end
    endtask

    task automatic run_burst();
        int n;
        int i;
        int start;
        n     = bq_pc.size();
        start = bus_reqs;
        for (i = 0; i <= n; i++) begin
            if (i < n) begin
                line_pc       = bq_pc[i];
                fetch_valid_i = 1'b1;
                fetch_pc_i    = bq_pc[i];
                fetch_mask_i  = bq_mask[i];
            end else begin
                fetch_valid_i = 1'b0;
            end
            @(negedge clk);
            if (i < n && !fetch_ready_o) begin
                flag_mismatch($sformatf("hit stream stalled at pc %h", bq_pc[i]));
            end
            if (i > 0) begin
                if (!inst_valid_o) begin
                    flag_mismatch($sformatf("no streamed response for pc %h", bq_pc[i-1]));
                end
                echo_check(inst_pc_o, bq_pc[i-1], inst_mask_o, bq_mask[i-1]);
                exception_check(inst_exc_o, inst_ecode_o, 1'b0);
                compare_pair(inst_data_o, bq_data[i-1]);
            end
            next_cycle();
        end
        fill_count_check(bus_reqs - start, 0);
        bq_pc.delete();
        bq_mask.delete();
        bq_data.delete();
    endtask

    task automatic send_cacop(input logic [31:0] addr);
        int   waited;
        logic done;
        waited        = 0;
        done          = 1'b0;
        cacop_valid_i = 1'b1;
        cacop_addr_i  = addr;
        while (!done) begin
            @(negedge clk);
            done   = cacop_done_o;
            waited = waited + 1;
            if (!done && waited > TIMEOUT) begin
                abort_run("index invalidate was never accepted");
            end
            next_cycle();
        end
        cacop_valid_i = 1'b0;
    endtask

    // flush lands in the cycle after acceptance
    task automatic flushed_fetch(input logic [31:0] pc, input fetch_mask_t mask,
                                 input int fill);
        int start;
        start         = bus_reqs;
        line_pc       = pc;
        fetch_valid_i = 1'b1;
        fetch_pc_i    = pc;
        fetch_mask_i  = mask;
        await_ready();
        fetch_valid_i = 1'b0;
        flush_i       = 1'b1;
        @(negedge clk);
        if (inst_valid_o) begin
            flag_mismatch($sformatf("flushed fetch of pc %h still answered", pc));
        end
        next_cycle();
        flush_i = 1'b0;
        @(negedge clk);
        if (inst_valid_o) begin
            flag_mismatch($sformatf("flushed fetch of pc %h answered late", pc));
        end
        next_cycle();
        fill_count_check(bus_reqs - start, fill);
    endtask

    // line model, every word is its byte address xor a fixed pattern
    initial begin : bus_model
        int unsigned gap;
        int          w;
        logic [31:0] base;
        void'($urandom(32'h534567cb));
        mem_ack_i        = 1'b0;
        mem_data_valid_i = 1'b0;
        mem_data_i       = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req_o) begin
                base     = mem_addr_o;
                bus_reqs = bus_reqs + 1;
                if (base !== {line_pc[31:5], 5'b0}) begin
                    flag_mismatch($sformatf("bus address %h for pc %h", base, line_pc));
                end
                if (mem_len_o !== 8'd8) begin
                    flag_mismatch($sformatf("bus length %0d, expected 8", mem_len_o));
                end
                gap = $urandom % 3;
                repeat (gap) next_cycle();
                next_cycle();
                mem_ack_i = 1'b1;
                next_cycle();
                mem_ack_i = 1'b0;
                for (w = 0; w < 8; w++) begin
                    gap = $urandom % 3;
                    repeat (gap) next_cycle();
                    mem_data_valid_i = 1'b1;
                    mem_data_i       = (base + 32'(4 * w)) ^ 32'hA5A5_0000;
                    next_cycle();
                    mem_data_valid_i = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        int          fd;
        int          fields;
        int          lines_run;
        int          fill;
        string       line;
        string       op;
        logic [31:0] addr;
        logic [31:0] w0;
        logic [31:0] w1;
        fetch_mask_t mask;
        logic        exc;
        lines_run     = 0;
        rst_n         = 1'b0;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_mask_i  = '0;
        cacop_valid_i = 1'b0;
        cacop_addr_i  = '0;
        line_pc       = '0;
        repeat (10) next_cycle();
        rst_n = 1'b1;
        @(negedge clk);
        if (!fetch_ready_o || inst_valid_o || mem_req_o || cacop_done_o) begin
            flag_mismatch("outputs not idle after reset");
        end
        next_cycle();

        fd = $fopen("tests/icache_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/icache_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %d %h %h", op, addr, mask, exc, fill, w0, w1);
            if (fields != 7) begin
                abort_run($sformatf("stimulus line not understood: %s", line));
            end
            lines_run = lines_run + 1;
            if (op == "burst") begin
                bq_pc.push_back(addr);
                bq_mask.push_back(mask);
                bq_data.push_back({w1, w0});
            end else begin
                if (bq_pc.size() > 0) begin
                    run_burst();
                end
                if (op == "fetch") begin
                    issue_fetch(addr, mask, exc, fill, {w1, w0});
                end else if (op == "cacop") begin
                    send_cacop(addr);
                end else if (op == "flush") begin
                    flushed_fetch(addr, mask, fill);
                end else begin
                    abort_run($sformatf("unknown operation %s in stimulus file", op));
                end
            end
        end
        if (bq_pc.size() > 0) begin
            run_burst();
        end
        $fclose(fd);
        if (lines_run == 0) begin
            abort_run("stimulus file holds no operations");
        end
        repeat (3) next_cycle();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/icache_stimulus.txt
# op    addr     mask exc fill word0    word1
# fill is the number of line refills expected, words are the pair at addr and addr+4
fetch   00001048 3    0   1    a5a51048 a5a5104c
fetch   00001040 3    0   0    a5a51040 a5a51044
burst   00001050 3    0   0    a5a51050 a5a51054
burst   00001058 2    0   0    a5a51058 a5a5105c
burst   00001040 1    0   0    a5a51040 a5a51044
fetch   00002040 3    0   1    a5a52040 a5a52044
fetch   00003048 3    0   1    a5a53048 a5a5304c
fetch   00002058 3    0   0    a5a52058 a5a5205c
fetch   00001040 3    0   1    a5a51040 a5a51044
cacop   00000040 0    0   0    00000000 00000000
fetch   00001058 3    0   0    a5a51058 a5a5105c
fetch   00003040 3    0   1    a5a53040 a5a53044
cacop   00000041 0    0   0    00000000 00000000
fetch   00003050 3    0   0    a5a53050 a5a53054
fetch   00001048 3    0   1    a5a51048 a5a5104c
fetch   00001042 3    1   0    00000000 00000000
fetch   00005001 1    1   0    00000000 00000000
fetch   00004f78 3    0   1    a5a54f78 a5a54f7c
fetch   00004f60 3    0   0    a5a54f60 a5a54f64
flush   00001048 3    0   0    00000000 00000000
fetch   00001050 3    0   0    a5a51050 a5a51054
burst   00004f68 3    0   0    a5a54f68 a5a54f6c
burst   00003058 3    0   0    a5a53058 a5a5305c

// File: filelist.f
source/icache_pkg.sv
source/icache_fill_if.sv
source/icache_lookup.sv
source/icache_arrays.sv
source/icache_hit_check.sv
source/icache_refill.sv
source/icache_top.sv
tests/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for the failure line
rm -f sim.log
verilator --binary --timing --top-module icache_tb -f filelist.f -o icache_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1 || echo "simulation exited with an error"
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log || exit 1
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
